/* source/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	localparam int DATA_WIDTH = 8; // data bits per frame
	localparam int FRAME_BITS = DATA_WIDTH + 3; // start + data + parity + stop
	localparam int SYNC_STAGES = 3; // flops on the incoming line

	localparam logic START_BIT = 1'b0; // line level of the start bit
	localparam logic STOP_BIT = 1'b1; // stop bit, also the idle level

	// what the receiver hands out per frame
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data; // received byte
		logic parity_err; // sampled parity disagrees with the data
		logic frame_err; // stop bit seen low
	} rx_result_t;

	// receiver FSM
	typedef enum logic [2:0] {
		ST_IDLE = 3'd0, // waiting for a falling line
		ST_START = 3'd1, // half bit wait, then recheck start
		ST_DATA = 3'd2, // eight data samples
		ST_PARITY = 3'd3, // parity sample
		ST_STOP = 3'd4 // stop sample and result write
	} rx_state_t;

	// parity bit for a byte
	// even parity gives an even count of ones over data plus parity
	function automatic logic parity_of(
		input logic [DATA_WIDTH-1:0] data,
		input logic odd
	);
		logic p;
		p = ^data; // xor reduce
		return p ^ odd; // flip for odd parity
	endfunction

endpackage

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int CLOCKS_PER_BIT = 8, // cycles each serial bit is held
	parameter bit PARITY_ODD = 1'b0 // 0 even, 1 odd
) (
	input wire tx_clk,
	input wire reset_tx, // sync, active high
	input wire i_start, // one cycle request
	input wire [uart_pkg::DATA_WIDTH-1:0] i_data, // byte captured with the request
	output logic o_busy, // high for the whole frame
	output logic o_serial // line out, idles high
);

	import uart_pkg::*;

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT); // bit timer width
	localparam int IDX_W = $clog2(FRAME_BITS); // bit index width
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLOCKS_PER_BIT - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_BITS - 1);

	logic [FRAME_BITS-1:0] frame; // full frame, bit 0 goes out first
	logic [FRAME_BITS-2:0] shift_q; // bits still to send after the current one
	logic [CNT_W-1:0] bit_cnt; // cycles spent in the current bit
	logic [IDX_W-1:0] bit_idx; // which of the 11 bits is on the line
	logic accept; // request taken this cycle
	logic bit_done; // last cycle of the current bit

	assign accept = i_start & ~o_busy; // strobes while busy are dropped
	assign bit_done = (bit_cnt == LAST_CNT);

	// stop, parity, data msb..lsb, start
	assign frame = {STOP_BIT, parity_of(i_data, PARITY_ODD), i_data, START_BIT};

	// busy, bit timer, bit index and the line register
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			o_busy <= 1'b0;
			o_serial <= STOP_BIT; // idle level
			bit_cnt <= '0;
			bit_idx <= '0;
		end else if (accept) begin
			o_busy <= 1'b1; // busy from the next cycle on
			o_serial <= frame[0]; // start bit goes out right away
			bit_cnt <= '0;
			bit_idx <= '0;
		end else if (o_busy) begin
			if (bit_done) begin
				bit_cnt <= '0; // next bit interval
				if (bit_idx == LAST_IDX) begin
					o_busy <= 1'b0; // stop bit finished
					o_serial <= STOP_BIT; // hold idle
				end else begin
					o_serial <= shift_q[0]; // present next bit
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// frame payload, lsb first
	always_ff @(posedge tx_clk) begin
		if (accept) begin
			shift_q <= frame[FRAME_BITS-1:1]; // everything behind the start bit
		end else if (o_busy && bit_done) begin
			shift_q <= {STOP_BIT, shift_q[FRAME_BITS-2:1]}; // fill with idle level
		end
	end

endmodule

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int CLOCKS_PER_BIT = 8, // cycles per serial bit, even
	parameter bit PARITY_ODD = 1'b0 // 0 even, 1 odd
) (
	input wire tx_clk,
	input wire reset_tx, // sync, active high
	input wire i_serial, // asynchronous line in
	output logic o_valid, // one cycle per received frame
	output uart_pkg::rx_result_t o_result // held until the next pulse
);

	import uart_pkg::*;

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT); // sample timer width
	localparam int BIT_W = $clog2(DATA_WIDTH); // data bit index width
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLOCKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLOCKS_PER_BIT / 2 - 1);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_WIDTH - 1);

	logic [SYNC_STAGES-1:0] sync_q; // line synchronizer chain
	logic rx_line; // synchronized line
	logic line_q; // line one cycle earlier
	logic line_fall; // high to low on the synchronized line
	rx_state_t state; // receive FSM
	logic [CNT_W-1:0] bit_cnt; // cycles since the last sample point
	logic [BIT_W-1:0] bit_idx; // data bits gathered so far
	logic [DATA_WIDTH-1:0] data_q; // incoming byte, shifted in from the top
	logic parity_q; // sampled parity bit
	logic sample; // sample point in the current state

	assign rx_line = sync_q[SYNC_STAGES-1];
	assign line_fall = line_q & ~rx_line;

	// half a bit after the edge, then a full bit apart
	assign sample = (state == ST_START) ? (bit_cnt == HALF_CNT) : (bit_cnt == LAST_CNT);

	// synchronizer and edge history start at idle level
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q <= '1;
			line_q <= 1'b1;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], i_serial};
			line_q <= rx_line;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			o_valid <= 1'b0;
			o_result <= '0;
		end else begin
			o_valid <= 1'b0; // pulse only

			if (state == ST_IDLE || sample) begin
				bit_cnt <= '0; // restart the timer at each sample
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end

			case (state)
				ST_IDLE: begin
					if (line_fall) begin
						state <= ST_START; // possible start bit
					end
				end
				ST_START: begin
					if (sample) begin
						bit_idx <= '0;
						// a glitch that went high again is not a frame
						state <= (rx_line == START_BIT) ? ST_DATA : ST_IDLE;
					end
				end
				ST_DATA: begin
					if (sample) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_BIT) begin
							state <= ST_PARITY; // all eight in
						end
					end
				end
				ST_PARITY: begin
					if (sample) begin
						state <= ST_STOP;
					end
				end
				ST_STOP: begin
					if (sample) begin
						o_valid <= 1'b1;
						o_result.data <= data_q;
						o_result.parity_err <= (parity_q != parity_of(data_q, PARITY_ODD));
						o_result.frame_err <= (rx_line != STOP_BIT); // low stop bit
						state <= ST_IDLE; // ready for the next falling edge
					end
				end
				default: begin
					state <= ST_IDLE; // unused encodings
				end
			endcase
		end
	end

	// data and parity capture at the sample points
	always_ff @(posedge tx_clk) begin
		if (sample && state == ST_DATA) begin
			data_q <= {rx_line, data_q[DATA_WIDTH-1:1]}; // lsb arrives first
		end
		if (sample && state == ST_PARITY) begin
			parity_q <= rx_line;
		end
	end

endmodule

`default_nettype wire

/* source/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
	parameter int CLOCKS_PER_BIT = 8, // even, 4 or more
	parameter bit PARITY_ODD = 1'b0 // 0 even, 1 odd
) (
	input wire tx_clk,
	input wire reset_tx, // sync, active high
	input wire i_tx_start, // one cycle send request
	input wire [uart_pkg::DATA_WIDTH-1:0] i_tx_data, // byte to send
	output wire o_tx_busy, // frame in progress
	output wire o_serial, // transmit line
	input wire i_serial, // receive line
	output wire o_rx_valid, // frame received
	output wire uart_pkg::rx_result_t o_rx_result // byte and error flags
);

	// transmit half
	uart_tx #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.PARITY_ODD(PARITY_ODD)
	) tx0 (
		.tx_clk(tx_clk),
		.reset_tx(reset_tx),
		.i_start(i_tx_start),
		.i_data(i_tx_data),
		.o_busy(o_tx_busy),
		.o_serial(o_serial)
	);

	// receive half, its line comes from outside
	uart_rx #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT),
		.PARITY_ODD(PARITY_ODD)
	) rx0 (
		.tx_clk(tx_clk),
		.reset_tx(reset_tx),
		.i_serial(i_serial),
		.o_valid(o_rx_valid),
		.o_result(o_rx_result)
	);

endmodule

`default_nettype wire

/* verif/uart_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_assertions (
	input wire tx_clk,
	input wire reset_tx,
	input wire i_tx_start, // send strobe at the top
	input wire i_tx_busy, // transmitter busy level
	input wire i_serial_out, // transmit line
	input wire i_rx_valid // receive pulse
);

	// receive strobe lasts one cycle
	a_valid_pulse : assert property (@(posedge tx_clk) disable iff (reset_tx)
		i_rx_valid |=> !i_rx_valid)
		else $error("o_rx_valid high for two cycles in a row");

	// line idles high outside a frame
	a_idle_high : assert property (@(posedge tx_clk) disable iff (reset_tx)
		!i_tx_busy |-> i_serial_out)
		else $error("o_serial low while o_tx_busy is low");

	// accepted request shows up as busy next cycle
	a_start_busy : assert property (@(posedge tx_clk) disable iff (reset_tx)
		(i_tx_start && !i_tx_busy) |=> i_tx_busy)
		else $error("accepted start did not raise o_tx_busy");

endmodule

bind uart_top uart_assertions asrt0 (
	.tx_clk(tx_clk),
	.reset_tx(reset_tx),
	.i_tx_start(i_tx_start),
	.i_tx_busy(o_tx_busy),
	.i_serial_out(o_serial),
	.i_rx_valid(o_rx_valid)
);

`default_nettype wire

/* verif/tb_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;

	import uart_pkg::*;

	localparam int CPB = 8; // DUT default bit time
	localparam bit PAR_ODD = 1'b0; // DUT default, even parity
	localparam int N_CLEAN = 30; // plain loopback frames
	localparam int N_PARITY = 5; // frames with a flipped parity bit
	localparam int N_FRAMING = 5; // frames with a low stop bit
	localparam int N_FRAMES = N_CLEAN + N_PARITY + N_FRAMING;
	localparam int FRAME_CYCLES = FRAME_BITS * CPB; // busy length of one frame
	localparam int TIMEOUT_CYCLES = N_FRAMES * (FRAME_BITS * CPB + 20) + 2000;

	logic tx_clk;
	logic reset_tx;
	logic tx_start; // send strobe
	logic [DATA_WIDTH-1:0] tx_data;
	logic inject; // xored onto the line to corrupt bits
	wire tx_busy;
	wire serial_out; // transmitter line
	wire serial_in; // receiver line
	wire rx_valid;
	rx_result_t rx_result;

	int seed;
	int errors = 0;
	int sent = 0; // accepted strobes
	int received = 0; // o_rx_valid pulses
	int ignored = 0; // strobes issued while busy
	int cycles = 0;
	rx_result_t expected_q[$]; // results still due from the receiver

	assign serial_in = serial_out ^ inject; // external loopback

	uart_top dut0 (
		.tx_clk(tx_clk),
		.reset_tx(reset_tx),
		.i_tx_start(tx_start),
		.i_tx_data(tx_data),
		.o_tx_busy(tx_busy),
		.o_serial(serial_out),
		.i_serial(serial_in),
		.o_rx_valid(rx_valid),
		.o_rx_result(rx_result)
	);

	initial begin
		tx_clk = 1'b0;
		forever #2 tx_clk = ~tx_clk; // 4 ns period
	end

	initial begin : watchdog
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge tx_clk);
			cycles = cycles + 1;
		end
		$display("timeout after %0d cycles with %0d of %0d frames received",
			cycles, received, sent);
		$display("Some tests failed");
		$finish;
	end

	// parity bit from a count of ones, flipped for odd parity
	function automatic logic parity_from_ones(input logic [DATA_WIDTH-1:0] d);
		int ones;
		ones = 0;
		for (int i = 0; i < DATA_WIDTH; i++) begin
			ones += d[i];
		end
		return (ones % 2 == 1) ^ PAR_ODD; // even parity makes the total even
	endfunction

	// line level of bit k of a frame carrying d
	function automatic logic expected_line_bit(input logic [DATA_WIDTH-1:0] d, input int k);
		if (k == 0) begin
			return 1'b0; // start
		end else if (k <= DATA_WIDTH) begin
			return d[k-1]; // data, lsb first
		end else if (k == DATA_WIDTH + 1) begin
			return parity_from_ones(d);
		end
		return 1'b1; // stop
	endfunction

	task automatic check_idle_outputs(input string when_txt);
		if (serial_out !== 1'b1) begin
			errors++;
			$display("[ERROR] o_serial %s: expected 0x1, got 0x%0h", when_txt, serial_out);
		end
		if (tx_busy !== 1'b0) begin
			errors++;
			$display("[ERROR] o_tx_busy %s: expected 0x0, got 0x%0h", when_txt, tx_busy);
		end
		if (rx_valid !== 1'b0) begin
			errors++;
			$display("[ERROR] o_rx_valid %s: expected 0x0, got 0x%0h", when_txt, rx_valid);
		end
	endtask

	// one frame from strobe to the first idle cycle, called 1 ns after an edge
	task automatic send_frame(input logic [DATA_WIDTH-1:0] d, input logic inj_par,
		input logic inj_stop, input logic extra);
		int c;
		int k;
		int extra_c;
		rx_result_t expected;
		extra_c = extra ? 10 + int'($unsigned($random(seed)) % 60) : -1; // busy strobe slot
		if (tx_busy !== 1'b0) begin
			errors++;
			$display("transmitter was still busy when a new frame was due");
		end
		expected.data = d;
		expected.parity_err = (expected_line_bit(d, DATA_WIDTH + 1) ^ inj_par)
			!= parity_from_ones(d);
		expected.frame_err = (1'b1 ^ inj_stop) != 1'b1;
		expected_q.push_back(expected);
		tx_start = 1'b1;
		tx_data = d;
		sent++;
		for (c = 0; c <= FRAME_CYCLES; c++) begin
			@(posedge tx_clk);
			#1;
			k = c / CPB; // bit on the line
			tx_start = (c == extra_c);
			if (c == extra_c) begin
				tx_data = ~d; // different data, must be dropped
				ignored++;
			end
			inject = (inj_par && k == DATA_WIDTH + 1) || (inj_stop && k == DATA_WIDTH + 2);
			if (c < FRAME_CYCLES && c % CPB == CPB / 2
				&& serial_out !== expected_line_bit(d, k)) begin
				errors++;
				$display("[ERROR] o_serial bit %0d of byte 0x%02h: expected 0x%0h, got 0x%0h",
					k, d, expected_line_bit(d, k), serial_out);
			end
			if (c < FRAME_CYCLES && tx_busy !== 1'b1) begin
				errors++;
				$display("[ERROR] o_tx_busy cycle %0d of byte 0x%02h: expected 0x1, got 0x%0h",
					c, d, tx_busy);
			end
			if (c == FRAME_CYCLES && tx_busy !== 1'b0) begin
				errors++;
				$display("[ERROR] o_tx_busy after frame 0x%02h: expected 0x0, got 0x%0h",
					d, tx_busy);
			end
		end
	endtask

	initial begin : rx_monitor
		rx_result_t expected;
		forever begin
			@(negedge tx_clk); // outputs settled
			if (rx_valid === 1'b1) begin
				received++;
				if (expected_q.size() == 0) begin
					errors++;
					$display("o_rx_valid pulsed with no frame outstanding");
				end else begin
					expected = expected_q.pop_front();
					if (rx_result.data !== expected.data) begin
						errors++;
						$display("[ERROR] o_rx_result.data: expected 0x%02h, got 0x%02h",
							expected.data, rx_result.data);
					end
					if (rx_result.parity_err !== expected.parity_err) begin
						errors++;
						$display("[ERROR] o_rx_result.parity_err: expected 0x%0h, got 0x%0h",
							expected.parity_err, rx_result.parity_err);
					end
					if (rx_result.frame_err !== expected.frame_err) begin
						errors++;
						$display("[ERROR] o_rx_result.frame_err: expected 0x%0h, got 0x%0h",
							expected.frame_err, rx_result.frame_err);
					end
				end
			end
		end
	end

	initial begin : main
		int n;
		int gap;
		logic [DATA_WIDTH-1:0] d;
		reset_tx = 1'b1;
		tx_start = 1'b0;
		tx_data = '0;
		inject = 1'b0;
		seed = 32'h1a44;
		repeat (8) begin
			@(posedge tx_clk);
			#1;
			check_idle_outputs("during reset");
		end
		reset_tx = 1'b0;
		@(posedge tx_clk);
		#1;
		check_idle_outputs("after reset");
		if (rx_result !== '0) begin
			errors++;
			$display("[ERROR] o_rx_result after reset: expected 0x000, got 0x%03h", rx_result);
		end
		for (n = 0; n < N_FRAMES; n++) begin
			gap = int'($unsigned($random(seed)) % 16); // idle cycles before the frame
			repeat (gap) begin
				@(posedge tx_clk);
				#1;
			end
			d = 8'($random(seed));
			send_frame(d, n >= N_CLEAN && n < N_CLEAN + N_PARITY,
				n >= N_CLEAN + N_PARITY, ($random(seed) & 1) == 1);
		end
		while (expected_q.size() != 0) begin
			@(posedge tx_clk); // watchdog covers a lost frame
		end
		repeat (4 * CPB) @(posedge tx_clk); // no late extra pulse allowed
		if (received != sent) begin
			errors++;
			$display("received %0d frames but %0d strobes were accepted", received, sent);
		end
		$display("sent %0d, received %0d, ignored strobes %0d, errors %0d",
			sent, received, ignored, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* uart_top.f */
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
verif/uart_assertions.sv
verif/tb_uart_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the UART testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_uart_top -f uart_top.f -o tb_uart_top &&
	./obj_dir/tb_uart_top 2>&1 | tee sim.log &&
	! grep -q "Some tests failed" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
